//--- telemetry_pkg.sv
`default_nettype none

package telemetry_pkg;

  // Record and packet framing
  localparam int RECORD_BITS = 32;
  localparam int PACKET_WORDS = 8;
  localparam int COUNT_BITS = $clog2(PACKET_WORDS);

  // Endpoint that carries the telemetry stream
  localparam logic [3:0] ENDPOINT_ADDR = 4'd2;

  // FIFO sizing
  localparam int FIFO_ABITS = 4;
  localparam int FIFO_DEPTH = 1 << FIFO_ABITS;
  localparam int LEVEL_BITS = FIFO_ABITS + 1;

  // Field widths inside a record
  localparam int PHY_BITS = 4;
  localparam int CTL_BITS = 4;
  localparam int BLK_BITS = 3;
  localparam int ERR_BITS = 3;
  localparam int USTATE_BITS = 4;
  localparam int TUSER_BITS = 4;
  localparam int ENDPT_BITS = 4;

  // Width of the one-hot bulk state from the core
  localparam int BLK_STATE_BITS = 8;

  // Field offsets, bit 31 down to 29 stay zero
  localparam int PHY_LSB = 0;
  localparam int CTL_LSB = 4;
  localparam int BLK_LSB = 8;
  localparam int SOF_BIT = 11;
  localparam int ERR_LSB = 12;
  localparam int CRC_BIT = 15;
  localparam int USTATE_LSB = 16;
  localparam int TUSER_LSB = 20;
  localparam int ENDPT_LSB = 24;
  localparam int BUSRST_BIT = 28;

  // Error codes, highest priority first
  localparam logic [ERR_BITS-1:0] ERR_TIMEOUT = 3'd7;
  localparam logic [ERR_BITS-1:0] ERR_SUSPEND = 3'd6;
  localparam logic [ERR_BITS-1:0] ERR_SENT = 3'd5;
  localparam logic [ERR_BITS-1:0] ERR_RECV = 3'd4;
  localparam logic [ERR_BITS-1:0] ERR_TOKEN = 3'd3;

  localparam logic [USTATE_BITS-1:0] USB_STATE_SUSPEND = 4'd8;

  // SOF decimation, HS has 8 SOFs per ms and FS has 1
  localparam int SOF_BITS = 8;
  localparam logic [SOF_BITS:0] SOF_STEP_HS = 9'd1;
  localparam logic [SOF_BITS:0] SOF_STEP_FS = 9'd8;

endpackage

`default_nettype wire

//--- telemetry_capture.sv
`default_nettype none

module telemetry_capture (
  input  wire                                 clock,
  input  wire                                 reset,
  input  wire                                 usb_enum_i,
  input  wire                                 usb_reset_i,
  input  wire                                 usb_sof_i,
  input  wire                                 usb_recv_i,
  input  wire                                 usb_sent_i,
  input  wire                                 tok_recv_i,
  input  wire                                 high_speed_i,
  input  wire                                 crc_error_i,
  input  wire                                 timeout_i,
  input  wire [3:0]                           usb_endpt_i,
  input  wire [3:0]                           usb_tuser_i,
  input  wire [3:0]                           phy_state_i,
  input  wire [3:0]                           usb_state_i,
  input  wire [3:0]                           ctl_state_i,
  input  wire [2:0]                           usb_error_i,
  input  wire [7:0]                           blk_state_i,
  output logic                                wr_valid_o,
  output logic                                wr_last_o,
  output logic [telemetry_pkg::RECORD_BITS-1:0] wr_record_o,
  input  wire                                 wr_ready_i
);

  import telemetry_pkg::*;

  logic [ERR_BITS-1:0]    err_code;
  logic [BLK_BITS-1:0]    blk_code;
  logic [SOF_BITS-1:0]    sof_count_q;
  logic [SOF_BITS:0]      sof_next;
  logic                   sof_in_q;
  logic                   sof_marker;
  logic [RECORD_BITS-1:0] curr_record;
  logic [RECORD_BITS-1:0] prev_record_q;
  logic [COUNT_BITS-1:0]  count_q;
  logic                   wr_fire;

  always_comb begin
    if (timeout_i) begin
      err_code = ERR_TIMEOUT;
    end else if (usb_state_i == USB_STATE_SUSPEND) begin
      err_code = ERR_SUSPEND;
    end else if (usb_sent_i) begin
      err_code = ERR_SENT;
    end else if (usb_recv_i) begin
      err_code = ERR_RECV;
    end else if (tok_recv_i) begin
      err_code = ERR_TOKEN;
    end else begin
      err_code = usb_error_i;
    end
  end

  // One-hot bulk state maps to its bit index and anything else to 7
  always_comb begin
    blk_code = '1;
    for (int i = 0; i < BLK_STATE_BITS - 1; i++) begin
      if (blk_state_i == (BLK_STATE_BITS'(1) << i)) begin
        blk_code = BLK_BITS'(i);
      end
    end
  end

  // Marker only on the SOF that carries the counter over
  assign sof_next = {1'b0, sof_count_q} + (high_speed_i ? SOF_STEP_HS : SOF_STEP_FS);
  assign sof_marker = usb_sof_i && sof_next[SOF_BITS];

  always_ff @(posedge clock) begin
    if (reset) begin
      sof_count_q <= '0;
      sof_in_q <= 1'b0;
    end else begin
      sof_in_q <= usb_sof_i;
      if (usb_sof_i && !sof_in_q) begin
        sof_count_q <= sof_next[SOF_BITS-1:0];
      end
    end
  end

  always_comb begin
    curr_record = '0;
    curr_record[PHY_LSB +: PHY_BITS] = phy_state_i;
    curr_record[CTL_LSB +: CTL_BITS] = ctl_state_i;
    curr_record[BLK_LSB +: BLK_BITS] = blk_code;
    curr_record[SOF_BIT] = sof_marker;
    curr_record[ERR_LSB +: ERR_BITS] = err_code;
    curr_record[CRC_BIT] = crc_error_i;
    curr_record[USTATE_LSB +: USTATE_BITS] = usb_state_i;
    curr_record[TUSER_LSB +: TUSER_BITS] = usb_tuser_i;
    curr_record[ENDPT_LSB +: ENDPT_BITS] = usb_endpt_i;
    curr_record[BUSRST_BIT] = usb_reset_i;
  end

  assign wr_record_o = curr_record;
  assign wr_valid_o = usb_enum_i && (curr_record != prev_record_q);
  assign wr_fire = wr_valid_o && wr_ready_i;
  assign wr_last_o = (count_q == COUNT_BITS'(PACKET_WORDS - 1));

  // Previous record follows every cycle, so a dropped change is lost
  always_ff @(posedge clock) begin
    if (reset) begin
      prev_record_q <= '0;
      count_q <= '0;
    end else begin
      prev_record_q <= curr_record;
      if (wr_fire) begin
        count_q <= count_q + 1'b1;
      end
    end
  end

  // The write that closes a packet starts the next one
  a_last_wraps: assert property (
    @(posedge clock) disable iff (reset) wr_fire && wr_last_o |=> !wr_last_o
  );

endmodule

`default_nettype wire

//--- telemetry_fifo.sv
`default_nettype none

module telemetry_fifo (
  input  wire                                   clock,
  input  wire                                   reset,
  input  wire                                   wr_valid_i,
  input  wire                                   wr_last_i,
  input  wire [telemetry_pkg::RECORD_BITS-1:0]  wr_record_i,
  output logic                                  wr_ready_o,
  output logic                                  rd_valid_o,
  output logic                                  rd_last_o,
  output logic [telemetry_pkg::RECORD_BITS-1:0] rd_record_o,
  input  wire                                   rd_ready_i,
  output logic [telemetry_pkg::LEVEL_BITS-1:0]  level_o
);

  import telemetry_pkg::*;

  // Each entry holds the last flag above the record
  logic [RECORD_BITS:0]  mem [FIFO_DEPTH];
  logic [FIFO_ABITS:0]   wr_ptr_q;
  logic [FIFO_ABITS:0]   rd_ptr_q;
  logic                  full;
  logic                  empty;
  logic                  wr_fire;
  logic                  rd_fire;

  // Same address with the wrap bits apart means full
  assign full = (wr_ptr_q[FIFO_ABITS] != rd_ptr_q[FIFO_ABITS]) &&
                (wr_ptr_q[FIFO_ABITS-1:0] == rd_ptr_q[FIFO_ABITS-1:0]);
  assign empty = (wr_ptr_q == rd_ptr_q);

  assign wr_ready_o = !full;
  assign rd_valid_o = !empty;
  assign wr_fire = wr_valid_i && wr_ready_o;
  assign rd_fire = rd_valid_o && rd_ready_i;

  // Show-ahead read straight from the array
  assign {rd_last_o, rd_record_o} = mem[rd_ptr_q[FIFO_ABITS-1:0]];

  assign level_o = wr_ptr_q - rd_ptr_q;

  always_ff @(posedge clock) begin
    if (wr_fire) begin
      mem[wr_ptr_q[FIFO_ABITS-1:0]] <= {wr_last_i, wr_record_i};
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (wr_fire) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (rd_fire) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  a_level_bounded: assert property (
    @(posedge clock) disable iff (reset) level_o <= LEVEL_BITS'(FIFO_DEPTH)
  );

  // Full with no read keeps the level at depth
  a_no_write_when_full: assert property (
    @(posedge clock) disable iff (reset)
      full && !rd_fire |=> level_o == LEVEL_BITS'(FIFO_DEPTH)
  );

endmodule

`default_nettype wire

//--- record_serializer.sv
`default_nettype none

module record_serializer (
  input  wire                                  clock,
  input  wire                                  reset,
  input  wire                                  rd_valid_i,
  input  wire                                  rd_last_i,
  input  wire [telemetry_pkg::RECORD_BITS-1:0] rd_record_i,
  output logic                                 rd_ready_o,
  output logic                                 byte_valid_o,
  output logic                                 byte_last_o,
  output logic [7:0]                           byte_data_o,
  input  wire                                  byte_ready_i
);

  import telemetry_pkg::*;

  logic [RECORD_BITS-1:0] record_q;
  logic                   last_q;
  logic                   loaded_q;
  logic [1:0]             index_q;
  logic                   rd_fire;
  logic                   byte_fire;

  // Idle only while nothing is held
  assign rd_ready_o = !loaded_q;
  assign rd_fire = rd_valid_i && rd_ready_o;
  assign byte_fire = byte_valid_o && byte_ready_i;

  assign byte_valid_o = loaded_q;
  assign byte_data_o = record_q[{index_q, 3'b000} +: 8];
  assign byte_last_o = loaded_q && last_q && (index_q == 2'd0);

  always_ff @(posedge clock) begin
    if (rd_fire) begin
      record_q <= rd_record_i;
      last_q <= rd_last_i;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      loaded_q <= 1'b0;
      index_q <= 2'd3;
    end else if (rd_fire) begin
      loaded_q <= 1'b1;
      index_q <= 2'd3;
    end else if (byte_fire) begin
      if (index_q == 2'd0) begin
        loaded_q <= 1'b0;
      end else begin
        index_q <= index_q - 2'd1;
      end
    end
  end

  a_byte_stable: assert property (
    @(posedge clock) disable iff (reset)
      byte_valid_o && !byte_ready_i |=> byte_valid_o && $stable(byte_data_o)
  );

endmodule

`default_nettype wire

//--- endpoint_gate.sv
`default_nettype none

module endpoint_gate (
  input  wire        clock,
  input  wire        reset,
  input  wire        usb_enum_i,
  input  wire        select_i,
  input  wire        start_i,
  input  wire [3:0]  endpt_i,
  input  wire        byte_valid_i,
  input  wire        byte_last_i,
  input  wire [7:0]  byte_data_i,
  output logic       byte_ready_o,
  output logic       m_tvalid_o,
  output logic       m_tlast_o,
  output logic [7:0] m_tdata_o,
  input  wire        m_tready_i
);

  import telemetry_pkg::*;

  logic selected_q;
  logic host_start;
  logic end_of_packet;

  assign host_start = usb_enum_i && select_i && start_i && (endpt_i == ENDPOINT_ADDR);
  assign end_of_packet = m_tvalid_o && m_tready_i && m_tlast_o;

  // A new start wins over the closing byte
  always_ff @(posedge clock) begin
    if (reset) begin
      selected_q <= 1'b0;
    end else if (host_start) begin
      selected_q <= 1'b1;
    end else if (end_of_packet) begin
      selected_q <= 1'b0;
    end
  end

  assign byte_ready_o = selected_q && m_tready_i;
  assign m_tvalid_o = selected_q && byte_valid_i;
  assign m_tlast_o = selected_q && byte_last_i;
  assign m_tdata_o = selected_q ? byte_data_i : 8'h00;

endmodule

`default_nettype wire

//--- bulk_telemetry.sv
`default_nettype none

module bulk_telemetry (
  input  wire                                  clock,
  input  wire                                  reset,
  input  wire                                  usb_enum_i,
  input  wire                                  usb_reset_i,
  input  wire                                  usb_sof_i,
  input  wire                                  usb_recv_i,
  input  wire                                  usb_sent_i,
  input  wire                                  tok_recv_i,
  input  wire                                  high_speed_i,
  input  wire                                  crc_error_i,
  input  wire                                  timeout_i,
  input  wire [3:0]                            usb_endpt_i,
  input  wire [3:0]                            usb_tuser_i,
  input  wire [3:0]                            phy_state_i,
  input  wire [3:0]                            usb_state_i,
  input  wire [3:0]                            ctl_state_i,
  input  wire [2:0]                            usb_error_i,
  input  wire [7:0]                            blk_state_i,
  input  wire                                  select_i,
  input  wire                                  start_i,
  input  wire [3:0]                            endpt_i,
  output logic                                 m_tvalid_o,
  output logic                                 m_tlast_o,
  output logic [7:0]                           m_tdata_o,
  input  wire                                  m_tready_i,
  output logic [telemetry_pkg::LEVEL_BITS-1:0] level_o
);

  import telemetry_pkg::*;

  logic                   wr_valid;
  logic                   wr_last;
  logic                   wr_ready;
  logic [RECORD_BITS-1:0] wr_record;
  logic                   rd_valid;
  logic                   rd_last;
  logic                   rd_ready;
  logic [RECORD_BITS-1:0] rd_record;
  logic                   byte_valid;
  logic                   byte_last;
  logic                   byte_ready;
  logic [7:0]             byte_data;

  telemetry_capture i_capture (
    .clock        (clock),
    .reset        (reset),
    .usb_enum_i   (usb_enum_i),
    .usb_reset_i  (usb_reset_i),
    .usb_sof_i    (usb_sof_i),
    .usb_recv_i   (usb_recv_i),
    .usb_sent_i   (usb_sent_i),
    .tok_recv_i   (tok_recv_i),
    .high_speed_i (high_speed_i),
    .crc_error_i  (crc_error_i),
    .timeout_i    (timeout_i),
    .usb_endpt_i  (usb_endpt_i),
    .usb_tuser_i  (usb_tuser_i),
    .phy_state_i  (phy_state_i),
    .usb_state_i  (usb_state_i),
    .ctl_state_i  (ctl_state_i),
    .usb_error_i  (usb_error_i),
    .blk_state_i  (blk_state_i),
    .wr_valid_o   (wr_valid),
    .wr_last_o    (wr_last),
    .wr_record_o  (wr_record),
    .wr_ready_i   (wr_ready)
  );

  telemetry_fifo i_fifo (
    .clock       (clock),
    .reset       (reset),
    .wr_valid_i  (wr_valid),
    .wr_last_i   (wr_last),
    .wr_record_i (wr_record),
    .wr_ready_o  (wr_ready),
    .rd_valid_o  (rd_valid),
    .rd_last_o   (rd_last),
    .rd_record_o (rd_record),
    .rd_ready_i  (rd_ready),
    .level_o     (level_o)
  );

  record_serializer i_serializer (
    .clock        (clock),
    .reset        (reset),
    .rd_valid_i   (rd_valid),
    .rd_last_i    (rd_last),
    .rd_record_i  (rd_record),
    .rd_ready_o   (rd_ready),
    .byte_valid_o (byte_valid),
    .byte_last_o  (byte_last),
    .byte_data_o  (byte_data),
    .byte_ready_i (byte_ready)
  );

  endpoint_gate i_gate (
    .clock        (clock),
    .reset        (reset),
    .usb_enum_i   (usb_enum_i),
    .select_i     (select_i),
    .start_i      (start_i),
    .endpt_i      (endpt_i),
    .byte_valid_i (byte_valid),
    .byte_last_i  (byte_last),
    .byte_data_i  (byte_data),
    .byte_ready_o (byte_ready),
    .m_tvalid_o   (m_tvalid_o),
    .m_tlast_o    (m_tlast_o),
    .m_tdata_o    (m_tdata_o),
    .m_tready_i   (m_tready_i)
  );

endmodule

`default_nettype wire

//--- tb_bulk_telemetry.sv
`default_nettype none

module tb_bulk_telemetry;

  import telemetry_pkg::*;

  typedef struct packed {
    logic       enumerated;
    logic       bus_rst;
    logic       sof;
    logic       recv;
    logic       sent;
    logic       tok;
    logic       hs;
    logic       crc;
    logic       tmo;
    logic [3:0] endpt;
    logic [3:0] tuser;
    logic [3:0] phy;
    logic [3:0] ustate;
    logic [3:0] ctl;
    logic [2:0] err;
    logic [7:0] blk;
    logic       sel;
    logic       start;
    logic [3:0] ep;
    logic       ready;
    logic       rnd;
  } row_t;

  logic clock = 1'b0;
  logic reset = 1'b1;
  logic usb_enum, usb_reset, usb_sof, usb_recv, usb_sent, tok_recv;
  logic high_speed, crc_error, timeout;
  logic [3:0] usb_endpt, usb_tuser, phy_state, usb_state, ctl_state;
  logic [2:0] usb_error;
  logic [7:0] blk_state;
  logic host_select, host_start, m_tready;
  logic [3:0] host_endpt;
  logic m_tvalid, m_tlast;
  logic [7:0] m_tdata;
  logic [LEVEL_BITS-1:0] level;

  row_t rows[$];
  row_t cur;
  logic table_ready = 1'b0;

  // Reference model state
  logic [RECORD_BITS-1:0] prev_rec;
  logic [SOF_BITS-1:0] sof_cnt;
  logic sof_prev, ser_busy, gate_sel, saw_full;
  int fifo_cnt, word_cnt, ser_left, dropped;
  logic [8:0] exp_bytes[$];

  always #4 clock = ~clock;

  bulk_telemetry i_dut (
    .clock        (clock),
    .reset        (reset),
    .usb_enum_i   (usb_enum),
    .usb_reset_i  (usb_reset),
    .usb_sof_i    (usb_sof),
    .usb_recv_i   (usb_recv),
    .usb_sent_i   (usb_sent),
    .tok_recv_i   (tok_recv),
    .high_speed_i (high_speed),
    .crc_error_i  (crc_error),
    .timeout_i    (timeout),
    .usb_endpt_i  (usb_endpt),
    .usb_tuser_i  (usb_tuser),
    .phy_state_i  (phy_state),
    .usb_state_i  (usb_state),
    .ctl_state_i  (ctl_state),
    .usb_error_i  (usb_error),
    .blk_state_i  (blk_state),
    .select_i     (host_select),
    .start_i      (host_start),
    .endpt_i      (host_endpt),
    .m_tvalid_o   (m_tvalid),
    .m_tlast_o    (m_tlast),
    .m_tdata_o    (m_tdata),
    .m_tready_i   (m_tready),
    .level_o      (level)
  );

  task automatic abort_run();
    $display("Test FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_value(string name, logic [31:0] actual, logic [31:0] expected);
    if (actual !== expected) begin
      $display("Fail %s: got 0x%h, expected 0x%h", name, actual, expected);
      abort_run();
    end
  endtask

  task automatic push_rows(int n);
    for (int k = 0; k < n; k++) begin
      rows.push_back(cur);
    end
  endtask

  // One cycle of host start followed by the idle selection request
  task automatic start_transfer(logic en, logic sel, logic [3:0] ep);
    cur.enumerated = en;
    cur.sel = sel;
    cur.ep = ep;
    cur.start = 1'b1;
    push_rows(1);
    cur.start = 1'b0;
    cur.enumerated = 1'b1;
    cur.sel = 1'b1;
    cur.ep = ENDPOINT_ADDR;
  endtask

  task automatic sof_pulses(int n);
    for (int k = 0; k < n; k++) begin
      cur.sof = 1'b1;
      push_rows(1);
      cur.sof = 1'b0;
      push_rows(1);
    end
  endtask

  task automatic build_table();
    cur = '0;
    cur.ready = 1'b1;
    // Changes while not enumerated write nothing
    cur.phy = 4'h1;
    push_rows(2);
    cur.phy = 4'h2;
    push_rows(2);
    cur.enumerated = 1'b1;
    push_rows(2);
    start_transfer(1'b1, 1'b1, ENDPOINT_ADDR);
    for (int s = 0; s < 17; s++) begin
      case (s)
        0: cur.phy = 4'h3;
        1: cur.ctl = 4'h5;
        2: cur.blk = 8'h04;
        3: cur.blk = 8'h80;
        4: cur.blk = 8'h01;
        5: cur.blk = 8'h06;
        6: cur.blk = 8'h00;
        7: cur.crc = 1'b1;
        8: cur.err = 3'd2;
        9: cur.tok = 1'b1;
        10: cur.recv = 1'b1;
        11: cur.sent = 1'b1;
        12: cur.ustate = USB_STATE_SUSPEND;
        13: cur.tmo = 1'b1;
        14: cur.ustate = 4'h0;
        15: cur.tmo = 1'b0;
        default: cur.sent = 1'b0;
      endcase
      push_rows(3);
    end
    push_rows(3);
    start_transfer(1'b1, 1'b1, ENDPOINT_ADDR);
    push_rows(60);
    // Starts that must not open the gate
    start_transfer(1'b1, 1'b1, 4'h3);
    cur.endpt = 4'h5;
    push_rows(3);
    start_transfer(1'b1, 1'b0, ENDPOINT_ADDR);
    cur.bus_rst = 1'b1;
    push_rows(3);
    start_transfer(1'b0, 1'b1, ENDPOINT_ADDR);
    cur.tuser = 4'h3;
    push_rows(10);
    start_transfer(1'b1, 1'b1, ENDPOINT_ADDR);
    push_rows(30);
    cur.hs = 1'b0;
    sof_pulses(40);
    cur.hs = 1'b1;
    sof_pulses(200);
    push_rows(20);
    // Host stalls until the FIFO overflows
    cur.ready = 1'b0;
    start_transfer(1'b1, 1'b1, ENDPOINT_ADDR);
    for (int k = 0; k < 24; k++) begin
      cur.phy = cur.phy + 4'h1;
      push_rows(2);
    end
    cur.rnd = 1'b1;
    for (int k = 0; k < 40; k++) begin
      if (k % 10 == 0) begin
        start_transfer(1'b1, 1'b1, ENDPOINT_ADDR);
      end
      cur.ctl = cur.ctl + 4'h1;
      push_rows(2);
    end
    cur.rnd = 1'b0;
    cur.ready = 1'b1;
    for (int k = 0; k < 12; k++) begin
      start_transfer(1'b1, 1'b1, ENDPOINT_ADDR);
      push_rows(24);
    end
  endtask

  task automatic drive_row(row_t r);
    logic [31:0] draw;
    draw = $urandom();
    usb_enum <= r.enumerated;
    usb_reset <= r.bus_rst;
    usb_sof <= r.sof;
    usb_recv <= r.recv;
    usb_sent <= r.sent;
    tok_recv <= r.tok;
    high_speed <= r.hs;
    crc_error <= r.crc;
    timeout <= r.tmo;
    usb_endpt <= r.endpt;
    usb_tuser <= r.tuser;
    phy_state <= r.phy;
    usb_state <= r.ustate;
    ctl_state <= r.ctl;
    usb_error <= r.err;
    blk_state <= r.blk;
    host_select <= r.sel;
    host_start <= r.start;
    host_endpt <= r.ep;
    m_tready <= r.rnd ? draw[0] : r.ready;
  endtask

  function automatic logic [RECORD_BITS-1:0] make_record(row_t r, logic marker);
    logic [RECORD_BITS-1:0] rec;
    logic [ERR_BITS-1:0] code;
    logic [BLK_BITS-1:0] blk_code;
    code = r.tmo ? ERR_TIMEOUT :
           (r.ustate == USB_STATE_SUSPEND) ? ERR_SUSPEND :
           r.sent ? ERR_SENT : r.recv ? ERR_RECV : r.tok ? ERR_TOKEN : r.err;
    blk_code = 3'd7;
    if ($countones(r.blk) == 1) begin
      for (int i = 0; i < 8; i++) begin
        if (r.blk[i]) begin
          blk_code = 3'(i);
        end
      end
    end
    rec = '0;
    rec[PHY_LSB +: PHY_BITS] = r.phy;
    rec[CTL_LSB +: CTL_BITS] = r.ctl;
    rec[BLK_LSB +: BLK_BITS] = blk_code;
    rec[SOF_BIT] = marker;
    rec[ERR_LSB +: ERR_BITS] = code;
    rec[CRC_BIT] = r.crc;
    rec[USTATE_LSB +: USTATE_BITS] = r.ustate;
    rec[TUSER_LSB +: TUSER_BITS] = r.tuser;
    rec[ENDPT_LSB +: ENDPT_BITS] = r.endpt;
    rec[BUSRST_BIT] = r.bus_rst;
    return rec;
  endfunction

  // Checks the outputs of this cycle and advances the model past the next edge
  task automatic model_step(row_t r);
    logic [SOF_BITS:0] sof_sum;
    logic [RECORD_BITS-1:0] rec;
    logic [8:0] want;
    logic accepted;
    logic wr;
    logic rd;
    sof_sum = {1'b0, sof_cnt} + (r.hs ? SOF_STEP_HS : SOF_STEP_FS);
    rec = make_record(r, r.sof && sof_sum[SOF_BITS]);
    check_value("level_o", 32'(level), 32'(fifo_cnt));
    check_value("m_tvalid_o", 32'(m_tvalid), 32'(gate_sel && ser_busy));
    if (!gate_sel) begin
      check_value("m_tdata_o", 32'(m_tdata), 32'h0);
      check_value("m_tlast_o", 32'(m_tlast), 32'h0);
    end
    accepted = m_tvalid && m_tready;
    want = '0;
    if (accepted) begin
      if (exp_bytes.size() == 0) begin
        $display("An output byte was accepted although no byte was expected");
        abort_run();
      end else begin
        want = exp_bytes.pop_front();
        check_value("m_tdata_o", 32'(m_tdata), 32'(want[7:0]));
        check_value("m_tlast_o", 32'(m_tlast), 32'(want[8]));
      end
    end
    wr = r.enumerated && (rec != prev_rec);
    rd = !ser_busy && (fifo_cnt > 0);
    if (wr && fifo_cnt == FIFO_DEPTH) begin
      wr = 1'b0;
      dropped++;
    end
    if (wr) begin
      word_cnt++;
      for (int b = 3; b >= 0; b--) begin
        exp_bytes.push_back({(b == 0) && (word_cnt == PACKET_WORDS), rec[b*8 +: 8]});
      end
      if (word_cnt == PACKET_WORDS) begin
        word_cnt = 0;
      end
    end
    if (r.enumerated && r.sel && r.start && r.ep == ENDPOINT_ADDR) begin
      gate_sel = 1'b1;
    end else if (accepted && want[8]) begin
      gate_sel = 1'b0;
    end
    if (accepted) begin
      ser_left--;
      if (ser_left == 0) begin
        ser_busy = 1'b0;
      end
    end
    if (rd) begin
      ser_busy = 1'b1;
      ser_left = 4;
    end
    fifo_cnt = fifo_cnt + int'(wr) - int'(rd);
    if (fifo_cnt == FIFO_DEPTH) begin
      saw_full = 1'b1;
    end
    if (r.sof && !sof_prev) begin
      sof_cnt = sof_sum[SOF_BITS-1:0];
    end
    sof_prev = r.sof;
    prev_rec = rec;
  endtask

  initial begin
    wait (table_ready);
    repeat (rows.size() * 20) @(posedge clock);
    $display("Watchdog expired before the stimulus table finished");
    abort_run();
  end

  initial begin
    void'($urandom(32'hfc5a_f62b));
    cur = '0;
    drive_row(cur);
    prev_rec = '0;
    sof_cnt = '0;
    sof_prev = 1'b0;
    ser_busy = 1'b0;
    gate_sel = 1'b0;
    saw_full = 1'b0;
    fifo_cnt = 0;
    word_cnt = 0;
    ser_left = 0;
    dropped = 0;
    build_table();
    table_ready = 1'b1;
    repeat (3) @(posedge clock);
    reset <= 1'b0;
    for (int i = 0; i < rows.size(); i++) begin
      drive_row(rows[i]);
      @(negedge clock);
      model_step(rows[i]);
      @(posedge clock);
    end
    @(negedge clock);
    if (!saw_full || dropped == 0) begin
      $display("The stimulus never filled the FIFO far enough to drop a change");
      abort_run();
    end
    check_value("level_o", 32'(level), 32'h0);
    if (exp_bytes.size() == 0) begin
      $display("Test OK");
      $finish;
    end else begin
      $display("%0d expected bytes never came out of the DUT", exp_bytes.size());
      abort_run();
    end
  end

endmodule

`default_nettype wire

//--- list.f
telemetry_pkg.sv
telemetry_capture.sv
telemetry_fifo.sv
record_serializer.sv
endpoint_gate.sv
bulk_telemetry.sv
tb_bulk_telemetry.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line in the log
set -e
rm -rf obj_dir
verilator --binary --timing --assert -f list.f --top-module tb_bulk_telemetry -Mdir obj_dir
./obj_dir/Vtb_bulk_telemetry 2>&1 | tee sim.log
grep -q "^Test OK$" sim.log
echo "Simulation passed"
